//--- common/vlane_settings.svh
`ifndef VLANE_SETTINGS_SVH
`define VLANE_SETTINGS_SVH

// Lane array
`define VLANE_LANES      4
`define VLANE_ELEN       32
`define VLANE_BEAT_W     (`VLANE_LANES * `VLANE_ELEN)

// Largest register group, in beats
`define VLANE_MAX_GROUP  4

// Beat buffer between sequencer and lanes
`define VLANE_FIFO_DEPTH 4

`endif

//--- common/vlane_pkg.sv
`include "vlane_settings.svh"

package vlane_pkg;

    // Codes 11 to 15 are unused and produce zero
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_SRA  = 4'd7,
        OP_MINU = 4'd8,
        OP_MAXU = 4'd9,
        OP_MUL  = 4'd10
    } valu_op_e;

    typedef enum logic [1:0] {
        E8  = 2'd0,
        E16 = 2'd1,
        E32 = 2'd2
    } sew_e;

    typedef enum logic [1:0] {
        M1 = 2'd0,
        M2 = 2'd1,
        M4 = 2'd2
    } lmul_e;

    typedef enum logic {
        IDLE = 1'b0,
        SEND = 1'b1
    } seq_state_e;

    // Register 0 sits in the low bits of each operand group
    typedef struct packed {
        valu_op_e                                       op;
        sew_e                                           sew;
        lmul_e                                          lmul;
        logic [`VLANE_MAX_GROUP*`VLANE_BEAT_W-1:0]      op_a;
        logic [`VLANE_MAX_GROUP*`VLANE_BEAT_W-1:0]      op_b;
    } vcmd_t;

    typedef struct packed {
        valu_op_e                   op;
        sew_e                       sew;
        logic [`VLANE_BEAT_W-1:0]   a;
        logic [`VLANE_BEAT_W-1:0]   b;
        logic [1:0]                 index;
        logic                       last;
    } vbeat_t;

    typedef struct packed {
        logic [`VLANE_MAX_GROUP*`VLANE_BEAT_W-1:0]  data;
        logic [2:0]                                 nregs;
    } vres_t;

endpackage

//--- design/v_seq.sv
`include "vlane_settings.svh"

module v_seq (
    input  logic                valu_clk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  vlane_pkg::vcmd_t    cmd,
    output logic                beat_valid,
    input  logic                beat_ready,
    output vlane_pkg::vbeat_t   beat
);

    vlane_pkg::seq_state_e  state_q;
    vlane_pkg::vcmd_t       cmd_q;
    logic [1:0]             idx_q;
    logic [1:0]             last_idx;
    logic                   cmd_fire;
    logic                   beat_fire;

    assign cmd_ready  = (state_q == vlane_pkg::IDLE);
    assign beat_valid = (state_q == vlane_pkg::SEND);
    assign cmd_fire   = cmd_valid && cmd_ready;
    assign beat_fire  = beat_valid && beat_ready;

    // Index of the final beat for the captured group length
    always_comb begin
        case (cmd_q.lmul)
            vlane_pkg::M2: last_idx = 2'd1;
            vlane_pkg::M4: last_idx = 2'd3;
            default:       last_idx = 2'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Beat slicing
    ////////////////////////////////////////////////////////////////////////////

    assign beat.op    = cmd_q.op;
    assign beat.sew   = cmd_q.sew;
    assign beat.a     = cmd_q.op_a[idx_q*`VLANE_BEAT_W +: `VLANE_BEAT_W];
    assign beat.b     = cmd_q.op_b[idx_q*`VLANE_BEAT_W +: `VLANE_BEAT_W];
    assign beat.index = idx_q;
    assign beat.last  = (idx_q == last_idx);

    always_ff @(posedge valu_clk) begin
        if (cmd_fire) begin
            cmd_q <= cmd;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= vlane_pkg::IDLE;
            idx_q   <= 2'd0;
        end else begin
            case (state_q)
                vlane_pkg::IDLE: begin
                    if (cmd_fire) begin
                        state_q <= vlane_pkg::SEND;
                        idx_q   <= 2'd0;
                    end
                end
                vlane_pkg::SEND: begin
                    if (beat_fire) begin
                        if (beat.last) begin
                            state_q <= vlane_pkg::IDLE;
                        end else begin
                            idx_q <= idx_q + 2'd1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- design/beat_fifo.sv
`include "vlane_settings.svh"

module beat_fifo #(
    parameter int DEPTH = `VLANE_FIFO_DEPTH
) (
    input  logic                valu_clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  vlane_pkg::vbeat_t   in_beat,
    output logic                out_valid,
    input  logic                out_ready,
    output vlane_pkg::vbeat_t   out_beat
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    vlane_pkg::vbeat_t  mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign in_ready = (count < CNT_W'(DEPTH));
    assign wr_en    = in_valid && in_ready;
    // Refill output register whenever it is empty or being taken
    assign rd_en    = (count != '0) && (!out_valid || out_ready);

    always_ff @(posedge valu_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_beat;
        end
        if (rd_en) begin
            out_beat <= mem[rd_ptr];
        end
    end

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            if (rd_en) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

endmodule

//--- v_lanes/v_lane.sv
`include "vlane_settings.svh"

module v_lane (
    input  vlane_pkg::valu_op_e     op,
    input  vlane_pkg::sew_e         sew,
    input  logic [`VLANE_ELEN-1:0]  a,
    input  logic [`VLANE_ELEN-1:0]  b,
    output logic [`VLANE_ELEN-1:0]  result
);

    // One element on zero-extended operands
    // Caller keeps the low SEW bits
    function automatic logic [31:0] elem_op(
        input vlane_pkg::valu_op_e op_i,
        input logic [31:0]         x,
        input logic [31:0]         y,
        input vlane_pkg::sew_e     sew_i
    );
        logic [31:0] xs;
        logic [4:0]  sh;
        logic [31:0] r;
        case (sew_i)
            vlane_pkg::E8: begin
                xs = {{24{x[7]}}, x[7:0]};
                sh = {2'b00, y[2:0]};
            end
            vlane_pkg::E16: begin
                xs = {{16{x[15]}}, x[15:0]};
                sh = {1'b0, y[3:0]};
            end
            default: begin
                xs = x;
                sh = y[4:0];
            end
        endcase
        case (op_i)
            vlane_pkg::OP_ADD:  r = x + y;
            vlane_pkg::OP_SUB:  r = x - y;
            vlane_pkg::OP_AND:  r = x & y;
            vlane_pkg::OP_OR:   r = x | y;
            vlane_pkg::OP_XOR:  r = x ^ y;
            vlane_pkg::OP_SLL:  r = x << sh;
            vlane_pkg::OP_SRL:  r = x >> sh;
            vlane_pkg::OP_SRA:  r = $unsigned($signed(xs) >>> sh);
            vlane_pkg::OP_MINU: r = (x < y) ? x : y;
            vlane_pkg::OP_MAXU: r = (x < y) ? y : x;
            // Low word of the product is enough for any SEW
            vlane_pkg::OP_MUL:  r = x * y;
            default:            r = 32'd0;
        endcase
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Packed element split
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [31:0] t;
        result = '0;
        t      = '0;
        case (sew)
            vlane_pkg::E8: begin
                for (int i = 0; i < `VLANE_ELEN/8; i++) begin
                    t = elem_op(op, {24'd0, a[i*8 +: 8]}, {24'd0, b[i*8 +: 8]}, sew);
                    result[i*8 +: 8] = t[7:0];
                end
            end
            vlane_pkg::E16: begin
                for (int i = 0; i < `VLANE_ELEN/16; i++) begin
                    t = elem_op(op, {16'd0, a[i*16 +: 16]}, {16'd0, b[i*16 +: 16]}, sew);
                    result[i*16 +: 16] = t[15:0];
                end
            end
            vlane_pkg::E32: begin
                result = elem_op(op, a, b, sew);
            end
            default: result = '0;
        endcase
    end

endmodule

//--- v_lanes/v_lanes.sv
`include "vlane_settings.svh"

module v_lanes (
    input  logic                valu_clk,
    input  logic                arst_n,
    input  logic                beat_valid,
    output logic                beat_ready,
    input  vlane_pkg::vbeat_t   beat,
    output logic                res_valid,
    input  logic                res_ready,
    output vlane_pkg::vres_t    res
);

    logic [`VLANE_BEAT_W-1:0]   lane_res;
    logic [`VLANE_BEAT_W-1:0]   stage_data;
    logic [1:0]                 stage_index;
    logic                       stage_last;
    logic                       stage_valid;
    logic                       beat_fire;
    logic                       handoff;
    logic                       coll_take;
    vlane_pkg::vres_t           res_q;
    logic [`VLANE_MAX_GROUP*`VLANE_BEAT_W-1:0] coll_base;

    ////////////////////////////////////////////////////////////////////////////
    // Lane array
    ////////////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < `VLANE_LANES; g++) begin : g_lane
        v_lane i_lane (
            .op     (beat.op),
            .sew    (beat.sew),
            .a      (beat.a[g*`VLANE_ELEN +: `VLANE_ELEN]),
            .b      (beat.b[g*`VLANE_ELEN +: `VLANE_ELEN]),
            .result (lane_res[g*`VLANE_ELEN +: `VLANE_ELEN])
        );
    end

    // Collector is free when empty or its result leaves this edge
    assign handoff    = res_valid && res_ready;
    assign coll_take  = stage_valid && (!res_valid || res_ready);
    assign beat_ready = !stage_valid || coll_take;
    assign beat_fire  = beat_valid && beat_ready;
    assign coll_base  = handoff ? '0 : res_q.data;

    always_ff @(posedge valu_clk) begin
        if (beat_fire) begin
            stage_data  <= lane_res;
            stage_index <= beat.index;
            stage_last  <= beat.last;
        end
    end

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_valid <= 1'b0;
        end else if (beat_fire) begin
            stage_valid <= 1'b1;
        end else if (coll_take) begin
            stage_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Result collector
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge valu_clk or negedge arst_n) begin
        if (!arst_n) begin
            res_q     <= '0;
            res_valid <= 1'b0;
        end else if (coll_take) begin
            res_q.data <= coll_base;
            res_q.data[stage_index*`VLANE_BEAT_W +: `VLANE_BEAT_W] <= stage_data;
            res_q.nregs <= {1'b0, stage_index} + 3'd1;
            res_valid   <= stage_last;
        end else if (handoff) begin
            // Zero so that registers past LMUL read back empty
            res_q.data <= '0;
            res_valid  <= 1'b0;
        end
    end

    assign res = res_q;

endmodule

//--- design/v_exec_top.sv
`include "vlane_settings.svh"

module v_exec_top (
    input  logic                valu_clk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  vlane_pkg::vcmd_t    cmd,
    output logic                res_valid,
    input  logic                res_ready,
    output vlane_pkg::vres_t    res
);

    logic               seq_valid;
    logic               seq_ready;
    vlane_pkg::vbeat_t  seq_beat;
    logic               fifo_valid;
    logic               fifo_ready;
    vlane_pkg::vbeat_t  fifo_beat;

    v_seq i_seq (
        .valu_clk   (valu_clk),
        .arst_n     (arst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .beat_valid (seq_valid),
        .beat_ready (seq_ready),
        .beat       (seq_beat)
    );

    beat_fifo #(
        .DEPTH (`VLANE_FIFO_DEPTH)
    ) i_fifo (
        .valu_clk   (valu_clk),
        .arst_n     (arst_n),
        .in_valid   (seq_valid),
        .in_ready   (seq_ready),
        .in_beat    (seq_beat),
        .out_valid  (fifo_valid),
        .out_ready  (fifo_ready),
        .out_beat   (fifo_beat)
    );

    v_lanes i_lanes (
        .valu_clk   (valu_clk),
        .arst_n     (arst_n),
        .beat_valid (fifo_valid),
        .beat_ready (fifo_ready),
        .beat       (fifo_beat),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res        (res)
    );

endmodule

//--- tests/v_exec_checker.sv
`include "vlane_settings.svh"

module v_exec_checker (
    input  logic                valu_clk,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  logic                cmd_ready,
    input  vlane_pkg::vcmd_t    cmd,
    input  logic [2:0]          cmd_nregs,
    input  logic                res_valid,
    input  logic                res_ready,
    input  vlane_pkg::vres_t    res,
    output int                  err_count,
    output int                  checked,
    output int                  pending
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEAT_W  = `VLANE_BEAT_W;
    localparam int GROUP_W = `VLANE_MAX_GROUP * `VLANE_BEAT_W;

    vlane_pkg::vres_t   expect_q[$];
    vlane_pkg::vres_t   exp_res;
    vlane_pkg::vres_t   held_res;
    logic               held;
    logic               reset_checked;

    initial begin
        err_count     = 0;
        checked       = 0;
        pending       = 0;
        held          = 1'b0;
        reset_checked = 1'b0;
    end

    // One element of width w on zero-extended operands
    function automatic logic [31:0] elem_ref(input logic [3:0] op, input logic [31:0] x,
                                             input logic [31:0] y, input int w);
        logic [31:0] mask;
        logic [31:0] xs;
        logic [63:0] prod;
        logic [31:0] r;
        int          sh;
        mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
        sh   = int'(y[4:0]) % w;
        xs   = x[w-1] ? (x | ~mask) : x;
        prod = {32'd0, x} * {32'd0, y};
        case (op)
            4'd0:    r = x + y;
            4'd1:    r = x - y;
            4'd2:    r = x & y;
            4'd3:    r = x | y;
            4'd4:    r = x ^ y;
            4'd5:    r = x << sh;
            4'd6:    r = x >> sh;
            4'd7:    r = $signed(xs) >>> sh;
            4'd8:    r = (x < y) ? x : y;
            4'd9:    r = (x > y) ? x : y;
            4'd10:   r = prod[31:0];
            default: r = 32'd0;
        endcase
        return r & mask;
    endfunction

    function automatic vlane_pkg::vres_t expect_res(input vlane_pkg::vcmd_t c,
                                                    input logic [2:0] n);
        vlane_pkg::vres_t       e;
        logic [31:0]            mask;
        logic [31:0]            x;
        logic [31:0]            y;
        logic [GROUP_W-1:0]     elem;
        int                     w;
        int                     pos;
        e       = '0;
        e.nregs = n;
        case (c.sew)
            vlane_pkg::E8:  w = 8;
            vlane_pkg::E16: w = 16;
            default:        w = 32;
        endcase
        mask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
        // Registers past the group stay zero
        for (int r = 0; r < int'(n); r++) begin
            for (int k = 0; k < BEAT_W / w; k++) begin
                pos    = r * BEAT_W + k * w;
                x      = 32'(c.op_a >> pos) & mask;
                y      = 32'(c.op_b >> pos) & mask;
                elem   = GROUP_W'(elem_ref(c.op, x, y, w));
                e.data = e.data | (elem << pos);
            end
        end
        return e;
    endfunction

    task automatic compare_res(input vlane_pkg::vres_t e, input vlane_pkg::vres_t g);
        int bad;
        bad = -1;
        for (int r = `VLANE_MAX_GROUP - 1; r >= 0; r--) begin
            if (g.data[r*BEAT_W +: BEAT_W] !== e.data[r*BEAT_W +: BEAT_W]) begin
                bad = r;
            end
        end
        if (g.nregs !== e.nregs) begin
            err_count++;
            $display("[FAIL] %0t: result %0d nregs %0d, expected %0d",
                     $time, checked, g.nregs, e.nregs);
        end
        if (bad >= 0) begin
            err_count++;
            $display("[FAIL] %0t: result %0d register %0d is %h, expected %h", $time,
                     checked, bad, g.data[bad*BEAT_W +: BEAT_W], e.data[bad*BEAT_W +: BEAT_W]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Port monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge valu_clk) begin
        if (arst_n) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (!cmd_ready || res_valid) begin
                    err_count++;
                    $display("[FAIL] %0t: after reset cmd_ready %0b res_valid %0b",
                             $time, cmd_ready, res_valid);
                end
            end
            // A stalled result must hold still
            if (held && (!res_valid || res !== held_res)) begin
                err_count++;
                $display("[FAIL] %0t: res changed while waiting for res_ready", $time);
            end
            held     = res_valid && !res_ready;
            held_res = res;
            if (cmd_valid && cmd_ready) begin
                expect_q.push_back(expect_res(cmd, cmd_nregs));
            end
            if (res_valid && res_ready) begin
                if (expect_q.size() == 0) begin
                    err_count++;
                    $display("A result came out with no command waiting for it");
                end else begin
                    exp_res = expect_q.pop_front();
                    compare_res(exp_res, res);
                    checked++;
                end
            end
            pending = expect_q.size();
        end
    end

endmodule

//--- tests/tb_v_exec.sv
`include "vlane_settings.svh"

module tb_v_exec;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CMD_TIMEOUT   = 200;
    localparam int DRAIN_TIMEOUT = 1000;
    localparam int RANDOM_CMDS   = 30;
    localparam int OPERAND_WORDS = `VLANE_MAX_GROUP * `VLANE_LANES;

    // One command of the stimulus table
    // Expected register count in nregs
    typedef struct packed {
        logic [3:0]         op;
        vlane_pkg::sew_e    sew;
        vlane_pkg::lmul_e   lmul;
        logic [2:0]         nregs;
        logic [31:0]        seed;
        logic               stall;
    } entry_t;

    logic               valu_clk;
    logic               arst_n;
    logic               cmd_valid;
    logic               cmd_ready;
    vlane_pkg::vcmd_t   cmd;
    logic [2:0]         cmd_nregs;
    logic               res_valid;
    logic               res_ready;
    vlane_pkg::vres_t   res;
    logic               stall_on;
    logic [31:0]        bp_state;
    logic [31:0]        rng_state;
    entry_t             stim_q[$];
    int                 err_count;
    int                 checked;
    int                 pending;
    int                 timeouts;
    bit                 aborted;

    always #50 valu_clk = ~valu_clk;

    v_exec_top i_dut (
        .valu_clk  (valu_clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res)
    );

    v_exec_checker i_checker (
        .valu_clk  (valu_clk),
        .arst_n    (arst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .cmd_nregs (cmd_nregs),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .err_count (err_count),
        .checked   (checked),
        .pending   (pending)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////////////

    task automatic build_stimulus();
        vlane_pkg::lmul_e   l;
        logic [2:0]         n;
        for (int op = 0; op < 11; op++) begin
            for (int s = 0; s < 3; s++) begin
                stim_q.push_back('{4'(op), vlane_pkg::sew_e'(s), vlane_pkg::M1, 3'd1,
                                   32'h100 + 32'(op * 4 + s), 1'b0});
            end
        end
        // Register groups
        stim_q.push_back('{4'd0, vlane_pkg::E8, vlane_pkg::M2, 3'd2, 32'h210, 1'b0});
        stim_q.push_back('{4'd10, vlane_pkg::E16, vlane_pkg::M2, 3'd2, 32'h211, 1'b0});
        stim_q.push_back('{4'd7, vlane_pkg::E32, vlane_pkg::M4, 3'd4, 32'h212, 1'b0});
        stim_q.push_back('{4'd1, vlane_pkg::E8, vlane_pkg::M4, 3'd4, 32'h213, 1'b0});
        stim_q.push_back('{4'd9, vlane_pkg::E16, vlane_pkg::M4, 3'd4, 32'h214, 1'b0});
        // Unused encodings
        for (int op = 11; op < 16; op++) begin
            stim_q.push_back('{4'(op), vlane_pkg::E8, vlane_pkg::M1, 3'd1,
                               32'h300 + 32'(op), 1'b0});
        end
        stim_q.push_back('{4'd13, vlane_pkg::E16, vlane_pkg::M4, 3'd4, 32'h320, 1'b0});
        // Back-to-back traffic under res_ready stalls
        for (int i = 0; i < RANDOM_CMDS; i++) begin
            rng_state = xorshift32(rng_state);
            case (rng_state[9:8])
                2'd0: begin
                    l = vlane_pkg::M1;
                    n = 3'd1;
                end
                2'd1: begin
                    l = vlane_pkg::M2;
                    n = 3'd2;
                end
                default: begin
                    l = vlane_pkg::M4;
                    n = 3'd4;
                end
            endcase
            stim_q.push_back('{4'(rng_state[3:0] % 4'd11),
                               vlane_pkg::sew_e'(rng_state[5:4] % 2'd3), l, n,
                               rng_state, 1'b1});
        end
    endtask

    function automatic vlane_pkg::vcmd_t make_cmd(input entry_t e);
        vlane_pkg::vcmd_t   c;
        logic [31:0]        s;
        c      = '0;
        c.op   = vlane_pkg::valu_op_e'(e.op);
        c.sew  = e.sew;
        c.lmul = e.lmul;
        s      = e.seed ^ 32'hae91;
        if (s == 32'd0) begin
            s = 32'hae91;
        end
        for (int i = 0; i < OPERAND_WORDS; i++) begin
            s = xorshift32(s);
            c.op_a[i*32 +: 32] = s;
            s = xorshift32(s);
            c.op_b[i*32 +: 32] = s;
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_entry(input entry_t e, output bit failed);
        int waited;
        failed    = 1'b0;
        waited    = 0;
        cmd_valid <= 1'b1;
        cmd       <= make_cmd(e);
        cmd_nregs <= e.nregs;
        stall_on  <= e.stall;
        do begin
            @(posedge valu_clk);
            waited++;
        end while (!cmd_ready && waited < CMD_TIMEOUT);
        if (!cmd_ready) begin
            $display("Timeout: command was not accepted within %0d cycles", CMD_TIMEOUT);
            timeouts++;
            failed = 1'b1;
        end
    endtask

    task automatic wait_drain(output bit failed);
        int waited;
        failed = 1'b0;
        waited = 0;
        @(negedge valu_clk);
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge valu_clk);
            waited++;
        end
        if (pending != 0) begin
            $display("Timeout: %0d results never came out of the DUT", pending);
            timeouts++;
            failed = 1'b1;
        end
    endtask

    // Random back-pressure on the result port
    always @(posedge valu_clk) begin
        bp_state = xorshift32(bp_state);
        res_ready <= stall_on ? bp_state[0] : 1'b1;
    end

    initial begin
        valu_clk  = 1'b0;
        arst_n    = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        cmd_nregs = 3'd0;
        res_ready = 1'b0;
        stall_on  = 1'b0;
        bp_state  = 32'hae91;
        rng_state = 32'hae91;
        timeouts  = 0;
        aborted   = 1'b0;
        build_stimulus();
        repeat (10) @(posedge valu_clk);
        arst_n <= 1'b1;
        @(posedge valu_clk);
        foreach (stim_q[i]) begin
            if (!aborted) begin
                drive_entry(stim_q[i], aborted);
            end
        end
        cmd_valid <= 1'b0;
        stall_on  <= 1'b0;
        if (!aborted) begin
            wait_drain(aborted);
        end
        $display("Errors: %0d check failures, %0d timeouts, %0d of %0d results checked",
                 err_count, timeouts, checked, stim_q.size());
        if (err_count == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/vlane_pkg.sv
design/v_seq.sv
design/beat_fifo.sv
v_lanes/v_lane.sv
v_lanes/v_lanes.sv
design/v_exec_top.sv
tests/v_exec_checker.sv
tests/tb_v_exec.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_v_exec -o sim_v_exec \
    || { echo "Build failed"; exit 1; }

./obj_dir/sim_v_exec > sim.log 2>&1
cat sim.log

grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
